// File: verilog.f
+incdir+hw
hw/rob_pkg.sv
hw/branch_pkg.sv
hw/branch_alloc.sv
hw/branch_slot.sv
hw/branch_retire.sv
hw/branch_tracker.sv
bench/branch_tracker_properties.sv
bench/branch_tracker_tb.sv

// File: Bender.yml
package:
  name: branch_tracker

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rob_pkg.sv
      - hw/branch_pkg.sv
      - hw/branch_alloc.sv
      - hw/branch_slot.sv
      - hw/branch_retire.sv
      - hw/branch_tracker.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/branch_tracker_properties.sv
      - bench/branch_tracker_tb.sv

// File: bench/branch_tracker_tb.sv
`include "branch_defines.svh"

module branch_tracker_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import rob_pkg::*;
   import branch_pkg::*;

   logic          clk;
   logic          rst_n;
   dispatch_grp_t dispatch;
   resolve_evt_t  resolve;
   commit_evt_t   commit;
   logic          stall;
   logic          flush_valid;
   rob_idx_t      flush_idx;
   logic          unmatched;
   logic [2:0]    branch_count;

   logic [31:0]   lfsr;
   slot_state_e   m_state [`BRANCH_SLOTS]; // reference slots
   rob_idx_t      m_idx [`BRANCH_SLOTS];
   age_t          m_age [`BRANCH_SLOTS];
   age_t          m_age_cnt;
   logic          exp_flush;
   logic          exp_unmatched;
   rob_idx_t      exp_flush_idx;
   int            errors;
   int            checks;
   int            flushes;
   int            misses;
   int            drain_cycles;

   branch_tracker branch_tracker_i (.*);

   always #4 clk = ~clk;

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic int find_slot(input slot_state_e st, input int start);
      int s;
      for (int i = 0; i < `BRANCH_SLOTS; i++)
      begin
         s = (start + i) % `BRANCH_SLOTS;
         if (m_state[s] == st)
            return s;
      end
      return -1;
   endfunction

   function automatic int live_count();
      int n;
      n = 0;
      for (int s = 0; s < `BRANCH_SLOTS; s++)
         n += (m_state[s] != SLOT_FREE);
      return n;
   endfunction

   function automatic logic model_stall();
      int br;
      br = 0;
      for (int p = 0; p < `DISPATCH_WIDTH; p++)
         br += dispatch.branch_mask[p];
      return dispatch.valid &&
             ((br > `BRANCH_SLOTS - live_count()) || (resolve.valid && resolve.mispredict));
   endfunction

   task automatic check_outputs();
      checks++;
      if (flush_valid !== exp_flush)
      begin
         errors++;
         $display("Error: flush_valid = %h, expected %h", flush_valid, exp_flush);
      end
      if (exp_flush && flush_idx !== exp_flush_idx)
      begin
         errors++;
         $display("Error: flush_idx = %h, expected %h", flush_idx, exp_flush_idx);
      end
      if (unmatched !== exp_unmatched)
      begin
         errors++;
         $display("Error: unmatched = %h, expected %h", unmatched, exp_unmatched);
      end
      if (branch_count !== 3'(live_count()))
      begin
         errors++;
         $display("Error: branch_count = %h, expected %h", branch_count, live_count());
      end
   endtask

   task automatic drive_inputs(input logic drain);
      int slot;
      dispatch = '0;
      resolve  = '0;
      commit   = '0;
      if (drain)
      begin
         slot = find_slot(SLOT_PENDING, 0);
         if (slot >= 0)
            resolve = '{valid: 1'b1, mispredict: 1'b0, rob_idx: m_idx[slot]};
         slot = find_slot(SLOT_RESOLVED, 0);
         if (slot >= 0)
            commit = '{valid: 1'b1, rob_idx: m_idx[slot]};
         return;
      end
      dispatch.valid       = 1'(rand_bits(1));
      dispatch.branch_mask = 4'(rand_bits(4));
      dispatch.rob_tail    = rob_idx_t'(rand_bits(6));
      if (rand_bits(1))
         dispatch.rob_tail[5:2] = 4'hf; // near the wrap
      // live rob indices stay unique
      for (int p = 0; p < `DISPATCH_WIDTH; p++)
         for (int s = 0; s < `BRANCH_SLOTS; s++)
            if (m_state[s] != SLOT_FREE && m_idx[s] == dispatch.rob_tail + rob_idx_t'(p))
               dispatch.branch_mask[p] = 1'b0;
      if (rand_bits(2) != 0)
      begin
         resolve.valid      = 1'b1;
         resolve.mispredict = (rand_bits(3) == 0) && !exp_flush; // none in a flush cycle
         slot               = find_slot(SLOT_PENDING, rand_bits(2));
         resolve.rob_idx    = (slot >= 0 && rand_bits(2) != 0) ? m_idx[slot] :
                              rob_idx_t'(rand_bits(6));
      end
      if (rand_bits(2) != 0)
      begin
         commit.valid = 1'b1;
         slot         = find_slot(SLOT_RESOLVED, rand_bits(2));
         if (slot < 0 || rand_bits(3) == 0)
            slot = find_slot(SLOT_PENDING, rand_bits(2)); // not yet eligible
         commit.rob_idx = (slot >= 0 && rand_bits(3) != 0) ? m_idx[slot] :
                          rob_idx_t'(rand_bits(6));
      end
   endtask

   // next registered state of the reference slots
   task automatic update_model();
      logic [`BRANCH_SLOTS-1:0] res_hit;
      logic [`BRANCH_SLOTS-1:0] mis_hit;
      logic [`BRANCH_SLOTS-1:0] cmt_hit;
      logic [`BRANCH_SLOTS-1:0] kill;
      logic [`BRANCH_SLOTS-1:0] taken;
      logic                     mis_any;
      age_t                     mis_age;
      age_t                     diff;
      rob_idx_t                 mis_idx;
      logic                     accept;
      int                       k;
      slot_state_e              nxt [`BRANCH_SLOTS];
      mis_any = 1'b0;
      mis_age = '0;
      mis_idx = '0;
      taken   = '0;
      k       = 0;
      accept  = dispatch.valid && !model_stall();
      for (int s = 0; s < `BRANCH_SLOTS; s++)
      begin
         res_hit[s] = m_state[s] == SLOT_PENDING && resolve.valid &&
                      !resolve.mispredict && resolve.rob_idx == m_idx[s];
         mis_hit[s] = m_state[s] == SLOT_PENDING && resolve.valid &&
                      resolve.mispredict && resolve.rob_idx == m_idx[s];
         cmt_hit[s] = m_state[s] == SLOT_RESOLVED && commit.valid && commit.rob_idx == m_idx[s];
         if (mis_hit[s])
         begin
            mis_any = 1'b1;
            mis_age = m_age[s];
            mis_idx = m_idx[s];
         end
      end
      for (int s = 0; s < `BRANCH_SLOTS; s++)
      begin
         diff    = m_age[s] - mis_age;
         kill[s] = mis_any && m_state[s] != SLOT_FREE && (mis_hit[s] || (diff != 0 && diff < 8));
         nxt[s]  = m_state[s];
         if (kill[s] || cmt_hit[s])
            nxt[s] = SLOT_FREE;
         else if (res_hit[s])
            nxt[s] = SLOT_RESOLVED;
      end
      for (int p = 0; p < `DISPATCH_WIDTH; p++)
         if (accept && dispatch.branch_mask[p])
            for (int s = 0; s < `BRANCH_SLOTS; s++)
               if (!taken[s] && m_state[s] == SLOT_FREE)
               begin
                  taken[s] = 1'b1;
                  nxt[s]   = SLOT_PENDING;
                  m_idx[s] = dispatch.rob_tail + rob_idx_t'(p);
                  m_age[s] = m_age_cnt + age_t'(k);
                  k++;
                  break;
               end
      m_age_cnt     = m_age_cnt + age_t'(k);
      m_state       = nxt;
      exp_flush     = mis_any;
      exp_flush_idx = mis_any ? mis_idx : exp_flush_idx;
      exp_unmatched = (resolve.valid && !(|res_hit || |mis_hit)) || (commit.valid && !(|cmt_hit));
      flushes      += mis_any;
      misses       += exp_unmatched;
   endtask

   task automatic run_cycle(input logic drain);
      @(negedge clk);
      check_outputs();
      drive_inputs(drain);
      #1;
      if (stall !== model_stall())
      begin
         errors++;
         $display("Error: stall = %h, expected %h", stall, model_stall());
      end
      update_model();
   endtask

   initial
   begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      dispatch      = '0;
      resolve       = '0;
      commit        = '0;
      lfsr          = 32'h226a77b9;
      m_age_cnt     = '0;
      exp_flush     = 1'b0;
      exp_unmatched = 1'b0;
      exp_flush_idx = '0;
      errors        = 0;
      checks        = 0;
      flushes       = 0;
      misses        = 0;
      drain_cycles  = 0;
      for (int s = 0; s < `BRANCH_SLOTS; s++)
      begin
         m_state[s] = SLOT_FREE;
         m_idx[s]   = '0;
         m_age[s]   = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      for (int c = 0; c < 2000; c++)
         run_cycle(1'b0);

      // resolve and commit whatever is still live
      while ((branch_count != 0 || live_count() != 0) && drain_cycles < 100)
      begin
         run_cycle(1'b1);
         drain_cycles++;
      end
      @(negedge clk);
      check_outputs();
      if (branch_count != 0)
      begin
         errors++;
         $display("drain timed out with %0d branches still live", branch_count);
      end

      errors += branch_tracker_i.branch_tracker_properties_i.fails;
      $display("checks %0d, flushes %0d, unmatched %0d, errors %0d",
               checks, flushes, misses, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: bench/branch_tracker_properties.sv
module branch_tracker_properties (
   input logic       clk,
   input logic       rst_n,
   input logic       mispredict_now,
   input logic       stall,
   input logic       flush_valid,
   input logic [2:0] branch_count
);

   timeunit 1ns;
   timeprecision 100ps;

   int fails = 0; // failed assertions so far

   // flush report is a single-cycle pulse
   no_double_flush: assert property (
      @(posedge clk) disable iff (!rst_n) flush_valid |=> !flush_valid
   ) else
   begin
      fails++;
      $error("flush_valid high two cycles running");
   end

   // killed slot is freed and the group is held, so the count must fall
   count_drops_on_flush: assert property (
      @(posedge clk) disable iff (!rst_n) flush_valid |-> branch_count < $past(branch_count)
   ) else
   begin
      fails++;
      $error("branch_count did not drop with a flush");
   end

   // a shortage stall needs busy slots
   stall_has_cause: assert property (
      @(posedge clk) disable iff (!rst_n) stall && !mispredict_now |-> branch_count != 3'd0
   ) else
   begin
      fails++;
      $error("stall with every slot free");
   end

   // no flush without a mispredict, so none straight out of reset
   flush_needs_mispredict: assert property (
      @(posedge clk) disable iff (!rst_n) flush_valid |-> $past(mispredict_now)
   ) else
   begin
      fails++;
      $error("flush_valid high without a mispredict");
   end

endmodule

bind branch_tracker branch_tracker_properties branch_tracker_properties_i (
   .clk            (clk),
   .rst_n          (rst_n),
   .mispredict_now (mispredict_now),
   .stall          (stall),
   .flush_valid    (flush_valid),
   .branch_count   (branch_count)
);

// File: hw/branch_tracker.sv
`include "branch_defines.svh"

module branch_tracker (
   input  logic                   clk,
   input  logic                   rst_n,
   input  rob_pkg::dispatch_grp_t dispatch,
   input  rob_pkg::resolve_evt_t  resolve,
   input  rob_pkg::commit_evt_t   commit,
   output logic                   stall,
   output logic                   flush_valid,
   output rob_pkg::rob_idx_t      flush_idx,
   output logic                   unmatched,
   output logic [2:0]             branch_count
);

   import branch_pkg::*;

   logic         mispredict_now;
   slot_mask_t   slot_busy;
   slot_mask_t   kill;
   slot_fill_t   fill [`BRANCH_SLOTS];
   slot_status_t status [`BRANCH_SLOTS];

   assign mispredict_now = resolve.valid && resolve.mispredict;

   branch_alloc branch_alloc_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .dispatch       (dispatch),
      .mispredict_now (mispredict_now),
      .slot_busy      (slot_busy),
      .stall          (stall),
      .fill           (fill)
   );

   for (genvar g = 0; g < `BRANCH_SLOTS; g++)
   begin : g_slot
      branch_slot branch_slot_i (
         .clk     (clk),
         .rst_n   (rst_n),
         .fill    (fill[g]),
         .kill    (kill[g]),
         .resolve (resolve),
         .commit  (commit),
         .status  (status[g])
      );

      assign slot_busy[g] = status[g].busy;
   end

   branch_retire branch_retire_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .status        (status),
      .resolve_valid (resolve.valid),
      .commit_valid  (commit.valid),
      .kill          (kill),
      .flush_valid   (flush_valid),
      .flush_idx     (flush_idx),
      .unmatched     (unmatched),
      .branch_count  (branch_count)
   );

endmodule

// File: hw/branch_retire.sv
`include "branch_defines.svh"

module branch_retire (
   input  logic                     clk,
   input  logic                     rst_n,
   input  branch_pkg::slot_status_t status [`BRANCH_SLOTS],
   input  logic                     resolve_valid,
   input  logic                     commit_valid,
   output branch_pkg::slot_mask_t   kill,
   output logic                     flush_valid,
   output rob_pkg::rob_idx_t        flush_idx,
   output logic                     unmatched,
   output logic [2:0]               branch_count
);

   import rob_pkg::*;
   import branch_pkg::*;

   logic     mis_any;
   age_t     mis_age;
   rob_idx_t mis_idx;
   logic     res_any; // correct or mispredict hit
   logic     cmt_any;

   // at most one slot can hit, live rob indices are unique
   always_comb
   begin
      mis_any = 1'b0;
      mis_age = '0;
      mis_idx = '0;
      res_any = 1'b0;
      cmt_any = 1'b0;
      for (int s = 0; s < `BRANCH_SLOTS; s++)
      begin
         if (status[s].mis_hit)
         begin
            mis_any = 1'b1;
            mis_age = status[s].age;
            mis_idx = status[s].rob_idx;
         end
         res_any = res_any || status[s].res_hit || status[s].mis_hit;
         cmt_any = cmt_any || status[s].cmt_hit;
      end
   end

   // squash the mispredicted slot and everything allocated after it
   always_comb
   begin : kill_blk
      age_t diff;

      for (int s = 0; s < `BRANCH_SLOTS; s++)
      begin
         diff    = status[s].age - mis_age; // modulo 2**AGE_W
         kill[s] = mis_any && status[s].busy &&
                   (status[s].mis_hit || ((diff != '0) && !diff[`AGE_W-1]));
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         flush_valid <= 1'b0;
         unmatched   <= 1'b0;
      end
      else
      begin
         flush_valid <= mis_any;
         unmatched   <= (resolve_valid && !res_any) || (commit_valid && !cmt_any);
      end
   end

   always_ff @(posedge clk)
   begin
      if (mis_any)
         flush_idx <= mis_idx;
   end

   // live branches straight from the slot state registers
   always_comb
   begin
      branch_count = '0;
      for (int s = 0; s < `BRANCH_SLOTS; s++)
         branch_count = branch_count + 3'(status[s].busy);
   end

endmodule

// File: hw/branch_slot.sv
module branch_slot (
   input  logic                     clk,
   input  logic                     rst_n,
   input  branch_pkg::slot_fill_t   fill,
   input  logic                     kill,
   input  rob_pkg::resolve_evt_t    resolve,
   input  rob_pkg::commit_evt_t     commit,
   output branch_pkg::slot_status_t status
);

   import rob_pkg::*;
   import branch_pkg::*;

   slot_state_e state;
   rob_idx_t    rob_idx_q;
   age_t        age_q;
   logic        res_match;
   logic        cmt_match;

   assign res_match = resolve.valid && (resolve.rob_idx == rob_idx_q);
   assign cmt_match = commit.valid && (commit.rob_idx == rob_idx_q);

   // hits only count in the state where the event is legal
   assign status.busy    = (state != SLOT_FREE);
   assign status.rob_idx = rob_idx_q;
   assign status.age     = age_q;
   assign status.res_hit = (state == SLOT_PENDING) && res_match && !resolve.mispredict;
   assign status.mis_hit = (state == SLOT_PENDING) && res_match && resolve.mispredict;
   assign status.cmt_hit = (state == SLOT_RESOLVED) && cmt_match;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= SLOT_FREE;
      else if (kill) // mispredict squash wins over everything
         state <= SLOT_FREE;
      else
      begin
         case (state)
            SLOT_FREE:
               if (fill.write)
                  state <= SLOT_PENDING;
            SLOT_PENDING:
               if (status.res_hit)
                  state <= SLOT_RESOLVED;
            SLOT_RESOLVED:
               if (status.cmt_hit)
                  state <= SLOT_FREE;
            default:
               state <= SLOT_FREE;
         endcase
      end
   end

   // branch identity, written only into a free slot
   always_ff @(posedge clk)
   begin
      if (fill.write)
      begin
         rob_idx_q <= fill.rob_idx;
         age_q     <= fill.age;
      end
   end

endmodule

// File: hw/branch_alloc.sv
`include "branch_defines.svh"

module branch_alloc (
   input  logic                   clk,
   input  logic                   rst_n,
   input  rob_pkg::dispatch_grp_t dispatch,
   input  logic                   mispredict_now,
   input  branch_pkg::slot_mask_t slot_busy,
   output logic                   stall,
   output branch_pkg::slot_fill_t fill [`BRANCH_SLOTS]
);

   import rob_pkg::*;
   import branch_pkg::*;

   logic [2:0] br_cnt;   // branches in the offered group
   logic [2:0] free_cnt; // free slots, registered state only
   logic       accept;
   age_t       age_cnt;

   always_comb
   begin
      br_cnt = '0;
      for (int p = 0; p < `DISPATCH_WIDTH; p++)
         br_cnt = br_cnt + 3'(dispatch.branch_mask[p]);
   end

   always_comb
   begin
      free_cnt = '0;
      for (int s = 0; s < `BRANCH_SLOTS; s++)
         free_cnt = free_cnt + 3'(!slot_busy[s]);
   end

   // hold the group when short of slots or while a flush is in progress
   assign stall  = dispatch.valid && ((br_cnt > free_cnt) || mispredict_now);
   assign accept = dispatch.valid && !stall; // stall already covers mispredict

   // branch k in position order goes to the k-th lowest free slot
   always_comb
   begin : map_blk
      slot_mask_t taken;
      age_t       next_age;
      rob_idx_t   idx;
      logic       placed;

      taken    = '0;
      next_age = age_cnt;
      for (int s = 0; s < `BRANCH_SLOTS; s++)
         fill[s] = '0;

      for (int p = 0; p < `DISPATCH_WIDTH; p++)
      begin
         idx    = dispatch.rob_tail + rob_idx_t'(p); // wraps at rob depth
         placed = 1'b0;
         if (accept && dispatch.branch_mask[p])
         begin
            for (int s = 0; s < `BRANCH_SLOTS; s++)
            begin
               if (!placed && !slot_busy[s] && !taken[s])
               begin
                  fill[s].write   = 1'b1;
                  fill[s].rob_idx = idx;
                  fill[s].age     = next_age;
                  taken[s]        = 1'b1;
                  placed          = 1'b1;
               end
            end
            next_age = next_age + age_t'(1);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         age_cnt <= '0;
      else if (accept)
         age_cnt <= age_cnt + age_t'(br_cnt); // one age per accepted branch
   end

endmodule

// File: hw/branch_pkg.sv
`include "branch_defines.svh"

package branch_pkg;

   typedef enum logic [1:0] {
      SLOT_FREE     = 2'd0,
      SLOT_PENDING  = 2'd1, // waiting for resolve
      SLOT_RESOLVED = 2'd2  // correct, waiting for commit
   } slot_state_e;

   typedef logic [`BRANCH_SLOTS-1:0] slot_mask_t;

   typedef logic [`AGE_W-1:0] age_t;

   // allocator to slot write port
   typedef struct packed {
      logic              write;
      rob_pkg::rob_idx_t rob_idx;
      age_t              age;
   } slot_fill_t;

   // per slot view for the retire unit
   typedef struct packed {
      logic              busy;
      rob_pkg::rob_idx_t rob_idx;
      age_t              age;
      logic              res_hit; // correct resolve matched
      logic              mis_hit; // mispredict matched
      logic              cmt_hit; // commit matched
   } slot_status_t;

endpackage

// File: hw/rob_pkg.sv
`include "branch_defines.svh"

package rob_pkg;

   // position in the reorder buffer
   typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

   // one group from the dispatch stage
   typedef struct packed {
      logic                       valid;
      logic [`DISPATCH_WIDTH-1:0] branch_mask; // bit p set -> position p is a branch
      rob_idx_t                   rob_tail;    // rob index of position 0
   } dispatch_grp_t;

   // branch unit outcome
   typedef struct packed {
      logic     valid;
      logic     mispredict;
      rob_idx_t rob_idx;
   } resolve_evt_t;

   // branch leaving the rob head
   typedef struct packed {
      logic     valid;
      rob_idx_t rob_idx;
   } commit_evt_t;

endpackage

// File: hw/branch_defines.svh
`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// reorder buffer entries, index wraps modulo this
`define ROB_DEPTH 64

// instructions offered per dispatch group
`define DISPATCH_WIDTH 4

// in-flight branches tracked at once
`define BRANCH_SLOTS 4

// allocation age counter
// compared modulo 2**AGE_W, half the range counts as younger
`define AGE_W 4

`endif
